// ==== verilog/sd_dat_macros.svh ====
`ifndef SD_DAT_MACROS_SVH
`define SD_DAT_MACROS_SVH

// sizing for the DAT line data path

// words held by the host write FIFO
// keep this a power of two, the FIFO pointers wrap naturally
`define SD_DAT_FIFO_DEPTH 16

// longest block the controller accepts, in 32-bit words
// 16 words is a 64 byte block
`define SD_DAT_BLOCK_WORDS_MAX 16

// width of block lengths and FIFO fill levels
// one bit more than log2 of the depth so a full FIFO can be counted
`define SD_DAT_COUNT_W 5

// a write frame on the 4-bit bus is
//   1 start cycle, 8 nibbles per word, 16 crc cycles, 1 end cycle
// a read frame uses the same layout, driven by the card
// on a write the card holds DAT0 low as busy after the end bit
// all four lines carry their own crc16, x^16+x^12+x^5+1, seed zero

`endif

// ==== verilog/sd_dat_pkg.sv ====
`include "sd_dat_macros.svh"

package sd_dat_pkg;

	typedef logic [31:0] word_t;                     // host side data word
	typedef logic [3:0] nibble_t;                    // one value on DAT[3:0]
	typedef logic [15:0] crc16_t;                    // crc of a single DAT line
	typedef logic [`SD_DAT_COUNT_W-1:0] word_count_t; // block length or fill level

	// transfer controller
	typedef enum logic [1:0] {
		st_idle,        // waiting for start
		st_fifo_check,  // write only, wait for a whole block in the FIFO
		st_trans,       // kick the line engine
		st_trans_ready  // frame in flight, wait for frame_done
	} ctrl_state_t;

	// DAT line engine
	typedef enum logic [2:0] {
		ln_idle,
		ln_start,       // write start bit, all lines low
		ln_data,        // nibbles, msn first
		ln_crc,         // 16 crc bits per line
		ln_end,         // end bit, all lines high
		ln_busy,        // write, card holds DAT0 low
		ln_wait_start   // read, wait for the card's start bit
	} line_state_t;

endpackage

// ==== verilog/sd_dat_if.sv ====
`timescale 1ns/1ns

// controller to line engine link
interface sd_dat_if import sd_dat_pkg::*; ();

	logic go;             // one cycle, starts a frame
	logic dir;            // 1 read (card to host), 0 write, held for the frame
	word_count_t words;   // block length, held for the frame
	word_t tx_word;       // oldest FIFO word, next one to send
	logic tx_take;        // line engine consumes tx_word
	word_t rx_word;       // assembled read word
	logic rx_valid;       // rx_word strobe, one cycle
	logic frame_done;     // end of frame pulse
	logic crc_bad;        // qualified by frame_done

	modport ctrl (
		output go,
		output dir,
		output words,
		output tx_word,
		input  tx_take,
		input  frame_done,
		input  crc_bad
	);

	modport line (
		input  go,
		input  dir,
		input  words,
		input  tx_word,
		output tx_take,
		output rx_word,
		output rx_valid,
		output frame_done,
		output crc_bad
	);

endinterface

// ==== verilog/sd_dat_fifo.sv ====
`timescale 1ns/1ns
`include "sd_dat_macros.svh"

// host write buffer, first word fall through
module sd_dat_fifo import sd_dat_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        push,
	input  word_t       wr_data,
	input  logic        pop,
	output word_t       rd_data,
	output word_count_t level,
	output logic        full
);

	localparam int ptr_w = $clog2(`SD_DAT_FIFO_DEPTH);

	word_t mem [`SD_DAT_FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	word_count_t count;
	logic wr_en;
	logic rd_en;

	assign full = (count == word_count_t'(`SD_DAT_FIFO_DEPTH));
	assign wr_en = push && !full;         // push into a full buffer is lost
	assign rd_en = pop && (count != '0);  // pop on empty does nothing

	assign rd_data = mem[rd_ptr];         // oldest word always visible
	assign level = count;

	// storage array, written on accepted pushes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;    // both or neither, level unchanged
			endcase
		end
	end

	// fill level seen by the controller is the same count the host sees as full
	// the controller compares it against the latched block length
	// so a write starts only when every word of the block is queued
	// and the line engine never underruns mid frame

endmodule

// ==== verilog/sd_dat_ctrl.sv ====
`timescale 1ns/1ns
`include "sd_dat_macros.svh"

// block transfer sequencer
module sd_dat_ctrl import sd_dat_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        dir,          // 1 read, 0 write
	input  word_count_t block_words,
	input  word_count_t fifo_level,
	input  word_t       fifo_data,
	output logic        fifo_pop,
	sd_dat_if.ctrl      bus,
	output logic        busy,
	output logic        done,
	output logic        crc_error
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic dir_q;
	word_count_t words_q;
	word_count_t words_in;
	logic done_q;
	logic crc_error_q;
	logic accept;
	logic finish;

	// clamp an oversized request to the largest supported block
	assign words_in = (block_words > word_count_t'(`SD_DAT_BLOCK_WORDS_MAX)) ?
		word_count_t'(`SD_DAT_BLOCK_WORDS_MAX) : block_words;

	assign accept = (state == st_idle) && start;               // start ignored while busy
	assign finish = (state == st_trans_ready) && bus.frame_done;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_nxt = dir ? st_trans : st_fifo_check;  // a read has nothing to wait for
				end
			end
			st_fifo_check: begin
				if (fifo_level >= words_q) begin
					state_nxt = st_trans;                        // whole block queued
				end
			end
			st_trans: begin
				state_nxt = st_trans_ready;                     // go is out this cycle
			end
			st_trans_ready: begin
				if (bus.frame_done) begin
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			dir_q <= 1'b0;
			words_q <= '0;
			done_q <= 1'b0;
			crc_error_q <= 1'b0;
		end else begin
			state <= state_nxt;
			done_q <= finish;             // one cycle after frame_done, with busy falling
			if (accept) begin
				dir_q <= dir;               // held for the whole frame
				words_q <= words_in;
				crc_error_q <= 1'b0;        // stale error dropped at the next start
			end else if (finish) begin
				crc_error_q <= bus.crc_bad;
			end
		end
	end

	assign busy = (state != st_idle);
	assign done = done_q;
	assign crc_error = crc_error_q;

	assign bus.go = (state == st_trans);
	assign bus.dir = dir_q;
	assign bus.words = words_q;
	assign bus.tx_word = fifo_data;    // fifo is fwft, head word goes straight out
	assign fifo_pop = bus.tx_take;     // one pop per word consumed

endmodule

// ==== verilog/sd_dat_line.sv ====
`timescale 1ns/1ns

// DAT[3:0] serializer, deserializer and per line crc16
module sd_dat_line import sd_dat_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	sd_dat_if.line  bus,
	input  nibble_t card_in,
	output nibble_t card_out,
	output logic    card_oe
);

	line_state_t state;
	logic [2:0] nib_cnt;         // nibble within the word
	logic [3:0] crc_cnt;         // crc bit within the tail
	word_count_t word_cnt;
	word_count_t last_word;
	word_t shift;
	word_t tx_src;
	nibble_t tx_nib;
	nibble_t data_nib;           // nibble fed to the crcs
	nibble_t crc_msb;
	crc16_t crc [4];
	logic last_nib;
	logic mismatch;              // sticky, read crc compare
	logic frame_done_q;
	logic crc_bad_q;
	logic rx_valid_q;

	// one serial step of x^16+x^12+x^5+1
	function automatic crc16_t crc16_step(crc16_t c, logic b);
		logic fb;
		fb = c[15] ^ b;
		return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
	endfunction

	assign last_word = bus.words - word_count_t'(1);
	assign last_nib = (nib_cnt == 3'd7);
	assign tx_src = (nib_cnt == 3'd0) ? bus.tx_word : shift;  // fresh word on its first nibble
	assign tx_nib = tx_src[31:28];                             // msn first
	assign data_nib = bus.dir ? card_in : tx_nib;
	assign crc_msb = {crc[3][15], crc[2][15], crc[1][15], crc[0][15]};

	assign bus.tx_take = (state == ln_data) && !bus.dir && (nib_cnt == 3'd0);
	assign bus.rx_word = shift;  // full word sits here in the rx_valid cycle
	assign bus.rx_valid = rx_valid_q;
	assign bus.frame_done = frame_done_q;
	assign bus.crc_bad = crc_bad_q;

	always_comb begin
		card_oe = 1'b0;
		card_out = 4'hf;  // released lines idle high
		if (!bus.dir) begin
			case (state)
				ln_start: begin
					card_oe = 1'b1;
					card_out = 4'h0;
				end
				ln_data: begin
					card_oe = 1'b1;
					card_out = tx_nib;
				end
				ln_crc: begin
					card_oe = 1'b1;
					card_out = crc_msb;  // bit i is line i's crc
				end
				ln_end: card_oe = 1'b1;
				default: card_oe = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ln_idle;
			nib_cnt <= '0;
			crc_cnt <= '0;
			word_cnt <= '0;
			mismatch <= 1'b0;
			frame_done_q <= 1'b0;
			crc_bad_q <= 1'b0;
			rx_valid_q <= 1'b0;
		end else begin
			frame_done_q <= 1'b0;
			rx_valid_q <= 1'b0;
			case (state)
				ln_idle: begin
					if (bus.go) begin
						state <= bus.dir ? ln_wait_start : ln_start;
						nib_cnt <= '0;
						crc_cnt <= '0;
						word_cnt <= '0;
						mismatch <= 1'b0;
					end
				end
				ln_wait_start: if (card_in == 4'h0) state <= ln_data;  // start bit on all lines
				ln_start: state <= ln_data;
				ln_data: begin
					nib_cnt <= nib_cnt + 1'b1;
					if (last_nib) begin
						rx_valid_q <= bus.dir;
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == last_word) state <= ln_crc;
					end
				end
				ln_crc: begin
					crc_cnt <= crc_cnt + 1'b1;
					if (bus.dir && (card_in != crc_msb)) mismatch <= 1'b1;
					if (crc_cnt == 4'hf) state <= ln_end;
				end
				ln_end: begin
					if (bus.dir) begin
						state <= ln_idle;  // card's end bit seen, frame over
						frame_done_q <= 1'b1;
						crc_bad_q <= mismatch;
					end else begin
						state <= ln_busy;
					end
				end
				ln_busy: begin
					if (card_in[0]) begin  // card let go of DAT0
						state <= ln_idle;
						frame_done_q <= 1'b1;
						crc_bad_q <= 1'b0;
					end
				end
				default: state <= ln_idle;
			endcase
		end
	end

	// shift register and the per line crcs that restart at go
	always_ff @(posedge clk) begin
		case (state)
			ln_idle: begin
				if (bus.go) begin
					for (int i = 0; i < 4; i++) crc[i] <= '0;
				end
			end
			ln_data: begin
				shift <= bus.dir ? {shift[27:0], card_in} : {tx_src[27:0], 4'h0};
				for (int i = 0; i < 4; i++) crc[i] <= crc16_step(crc[i], data_nib[i]);
			end
			ln_crc: begin
				for (int i = 0; i < 4; i++) crc[i] <= {crc[i][14:0], 1'b0};  // msb out first
			end
			default: shift <= shift;
		endcase
	end

endmodule

// ==== verilog/sd_dat_top.sv ====
`timescale 1ns/1ns

// SD host DAT line data path
module sd_dat_top import sd_dat_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  word_t       buffer_in,
	input  logic        buffer_wr,
	output logic        fifo_full,
	output word_t       buffer_out,
	output logic        buffer_valid,
	input  logic        start,
	input  logic        dir,         // 1 read, 0 write
	input  word_count_t block_words,
	output logic        busy,
	output logic        done,
	output logic        crc_error,
	input  nibble_t     card_in,
	output nibble_t     card_out,
	output logic        card_oe
);

	logic fifo_pop;
	word_t fifo_data;
	word_count_t fifo_level;

	sd_dat_if bus ();

	sd_dat_fifo u_fifo (
		.clk     (clk),
		.reset   (reset),
		.push    (buffer_wr),
		.wr_data (buffer_in),
		.pop     (fifo_pop),
		.rd_data (fifo_data),
		.level   (fifo_level),
		.full    (fifo_full)
	);

	sd_dat_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.dir         (dir),
		.block_words (block_words),
		.fifo_level  (fifo_level),
		.fifo_data   (fifo_data),
		.fifo_pop    (fifo_pop),
		.bus         (bus.ctrl),
		.busy        (busy),
		.done        (done),
		.crc_error   (crc_error)
	);

	sd_dat_line u_line (
		.clk      (clk),
		.reset    (reset),
		.bus      (bus.line),
		.card_in  (card_in),
		.card_out (card_out),
		.card_oe  (card_oe)
	);

	assign buffer_out = bus.rx_word;     // read words, no back-pressure
	assign buffer_valid = bus.rx_valid;

endmodule

// ==== dv/sd_dat_assertions.sv ====
`timescale 1ns/1ns

// protocol checks on the DAT path top level, bound into sd_dat_top
module sd_dat_assertions import sd_dat_pkg::*; (
	input logic    clk,
	input logic    reset,
	input nibble_t card_out,
	input logic    card_oe,
	input logic    busy,
	input logic    done,
	input logic    buffer_valid
);

	int fail_count = 0;  // failures so far, summed into the testbench totals

	// released bus idles high
	released_idle: assert property (@(posedge clk) disable iff (reset)
		!card_oe |-> (card_out == 4'hf))
		else begin
			fail_count++;
			$error("card_out not all ones while card_oe is low");
		end

	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			fail_count++;
			$error("done held for more than one cycle");
		end

	done_after_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
		else begin
			fail_count++;
			$error("done without busy in the cycle before");
		end

	// the line engine only drives inside a transfer
	oe_in_transfer: assert property (@(posedge clk) disable iff (reset) $rose(card_oe) |-> busy)
		else begin
			fail_count++;
			$error("card_oe rose while busy is low");
		end

	valid_in_transfer: assert property (@(posedge clk) disable iff (reset) buffer_valid |-> busy)
		else begin
			fail_count++;
			$error("buffer_valid seen while busy is low");
		end

endmodule

bind sd_dat_top sd_dat_assertions u_assertions (.*);

// ==== dv/sd_dat_tb.sv ====
`timescale 1ns/1ns
`include "sd_dat_macros.svh"

// DAT path testbench, the card is modelled inline in the read and write tasks
module sd_dat_tb import sd_dat_pkg::*; ();

	logic clk = 1'b0;
	logic reset;
	word_t buffer_in;
	logic buffer_wr;
	logic fifo_full;
	word_t buffer_out;
	logic buffer_valid;
	logic start;
	logic dir;
	word_count_t block_words;
	logic busy;
	logic done;
	logic crc_error;
	nibble_t card_in;
	nibble_t card_out;
	logic card_oe;
	logic [31:0] rng = 32'h9c17_3f46;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int mark = 0;         // error total at the start of the running test
	word_t exp_q [$];     // pushed words not yet seen on the bus, oldest first

	sd_dat_top dut (.*);

	always #50 clk = ~clk;  // 100 ns period

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// crc16 of one DAT line, x^16+x^12+x^5+1 with the taps written per bit
	function automatic crc16_t line_crc(nibble_t nibs [$], int line);
		crc16_t c;
		logic fb;
		c = '0;
		foreach (nibs[k]) begin
			fb = c[15] ^ nibs[k][line];
			c = {c[14:12], c[11] ^ fb, c[10:5], c[4] ^ fb, c[3:0], fb};
		end
		return c;
	endfunction

	task automatic fail_check(string msg);
		errors++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic step();
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic finish_test(string name);
		int total;
		total = errors + dut.u_assertions.fail_count;
		tests_run++;
		if (total != mark) tests_failed++;
		$display("test %s: %s", name, (total == mark) ? "ok" : "FAILED");
		mark = total;
	endtask

	task automatic push_words(int n, bit keep);  // keep low for a word the FIFO must drop
		repeat (n) begin
			rng = xorshift32(rng);
			assert (!card_oe) else fail_check("card_oe high while the block is still queued");
			buffer_in = rng;
			buffer_wr = 1'b1;
			if (keep) exp_q.push_back(rng);
			step();
		end
		buffer_wr = 1'b0;
	endtask

	task automatic start_frame(logic rd, int n);
		start = 1'b1;
		dir = rd;
		block_words = word_count_t'(n);
		step();
		start = 1'b0;
		assert (busy && !crc_error) else fail_check("busy low or crc_error kept after start");
	endtask

	task automatic wait_done(string what);
		int t;
		for (t = 0; t < 200 && !done; t++) step();
		if (!done) begin
			errors++;
			$display("timeout: no done at the end of the %s", what);
		end else begin
			assert (!busy) else fail_check("busy still high in the done cycle");
		end
	endtask

	// card side of a write, frame capture, busy on DAT0, then the frame check
	task automatic run_write(int n, int hold);
		nibble_t frame [$];
		nibble_t data [$];
		word_t w;
		crc16_t c;
		crc16_t rc;
		int t;
		for (t = 0; t < 100 && !card_oe; t++) step();
		if (!card_oe) begin
			errors++;
			$display("timeout: write frame never started");
		end
		while (card_oe && frame.size() < 8 * n + 40) begin
			frame.push_back(card_out);
			step();
		end
		card_in[0] = 1'b0;  // first cycle after the end bit
		repeat (hold) begin
			step();
			assert (!done) else fail_check("done while the card holds DAT0 busy");
		end
		card_in = 4'hf;
		wait_done("write");
		assert (frame.size() == 8 * n + 18)
			else fail_check($sformatf("write frame lasted %0d cycles", frame.size()));
		if (frame.size() == 8 * n + 18) begin
			assert (frame[0] == 4'h0 && frame[8 * n + 17] == 4'hf)
				else fail_check("bad start or end cycle in write frame");
			for (int k = 0; k < n; k++) begin
				w = '0;
				for (int j = 0; j < 8; j++) begin
					w = {w[27:0], frame[1 + 8 * k + j]};  // msn arrives first
					data.push_back(frame[1 + 8 * k + j]);
				end
				assert (exp_q.size() > 0 && w == exp_q[0])
					else fail_check($sformatf("write word %0d is %h", k, w));
				if (exp_q.size() > 0) void'(exp_q.pop_front());
			end
			for (int i = 0; i < 4; i++) begin
				c = line_crc(data, i);
				rc = '0;
				for (int b = 0; b < 16; b++) rc = {rc[14:0], frame[8 * n + 1 + b][i]};
				assert (rc == c) else fail_check($sformatf("line %0d crc %h, model %h", i, rc, c));
			end
		end
	endtask

	// card side of a read, optionally with one crc bit flipped
	task automatic run_read(int n, bit flip);
		nibble_t data [$];
		nibble_t drive [$];
		word_t words [$];
		crc16_t crcs [4];
		nibble_t nib;
		int got;
		int t;
		for (int k = 0; k < n; k++) begin
			rng = xorshift32(rng);
			words.push_back(rng);
			for (int j = 0; j < 8; j++) data.push_back(rng[31 - 4 * j -: 4]);
		end
		for (int i = 0; i < 4; i++) crcs[i] = line_crc(data, i);
		rng = xorshift32(rng);
		if (flip) crcs[rng[1:0]][rng[7:4]] = ~crcs[rng[1:0]][rng[7:4]];
		drive = {4'hf, 4'hf, 4'hf, 4'h0};  // idle, then the start bit
		foreach (data[k]) drive.push_back(data[k]);
		for (int b = 0; b < 16; b++) begin
			for (int i = 0; i < 4; i++) nib[i] = crcs[i][15 - b];
			drive.push_back(nib);
		end
		drive.push_back(4'hf);             // end bit
		start_frame(1'b1, n);
		got = 0;
		for (t = 0; t < 8 * n + 60 && !done; t++) begin
			if (buffer_valid) begin
				assert (got < n && buffer_out == words[got])
					else fail_check($sformatf("read word %0d is %h", got, buffer_out));
				got++;
			end
			card_in = (drive.size() > 0) ? drive.pop_front() : 4'hf;
			step();
		end
		card_in = 4'hf;
		if (!done) begin
			errors++;
			$display("timeout: no done at the end of the read");
		end
		assert (got == n) else fail_check($sformatf("%0d read words for a block of %0d", got, n));
		assert (crc_error == flip) else fail_check($sformatf("crc_error %b after read", crc_error));
		assert (!busy) else fail_check("busy still high after read done");
	endtask

	initial begin
		int n;
		reset = 1'b1;
		buffer_in = '0;
		buffer_wr = 1'b0;
		start = 1'b0;
		dir = 1'b0;
		block_words = '0;
		card_in = 4'hf;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		step();
		assert (!card_oe && !busy && !done && !buffer_valid && !crc_error && card_out == 4'hf)
			else fail_check("outputs not at their reset values");
		finish_test("reset state");
		push_words(3, 1'b1);
		start_frame(1'b0, 8);
		repeat (20) begin
			step();
			assert (!card_oe) else fail_check("card_oe high with only 3 of 8 words queued");
		end
		push_words(5, 1'b1);
		run_write(8, 4);
		finish_test("write waits for block");
		push_words(5, 1'b1);
		start_frame(1'b0, 5);
		run_write(5, 7);
		finish_test("write frame");
		run_read(4, 1'b0);
		finish_test("read data");
		run_read(4, 1'b1);
		run_read(4, 1'b0);
		finish_test("read crc fault");
		push_words(`SD_DAT_FIFO_DEPTH, 1'b1);
		assert (fifo_full) else fail_check("fifo_full low with 16 words queued");
		push_words(1, 1'b0);
		start_frame(1'b0, `SD_DAT_FIFO_DEPTH);
		run_write(`SD_DAT_FIFO_DEPTH, 3);
		repeat (8) begin
			rng = xorshift32(rng);
			n = int'(rng[19:16] % `SD_DAT_BLOCK_WORDS_MAX) + 1;
			if (rng[8]) begin
				run_read(n, 1'b0);
			end else begin
				push_words(n, 1'b1);
				start_frame(1'b0, n);
				run_write(n, int'(rng[2:0]) + 1);
			end
		end
		assert (exp_q.size() == 0) else fail_check("pushed words never sent");
		finish_test("mixed sequence");
		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, dut.u_assertions.fail_count);
		if (tests_failed == 0 && errors == 0 && dut.u_assertions.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/sd_dat_pkg.sv
verilog/sd_dat_if.sv
verilog/sd_dat_fifo.sv
verilog/sd_dat_ctrl.sv
verilog/sd_dat_line.sv
verilog/sd_dat_top.sv
dv/sd_dat_assertions.sv
dv/sd_dat_tb.sv
